/* hdl/bus_console_params.svh */
`ifndef BUS_CONSOLE_PARAMS_SVH
`define BUS_CONSOLE_PARAMS_SVH

// data word carried to and from a master
`define BC_DATA_WIDTH 16

// master side address, covers the largest slave
`define BC_ADDR_WIDTH 12

// external words per master
`define BC_BANK_DEPTH 16

`define BC_MASTERS 2

// cycles in one configuration slot
`define BC_CFG_CLKS 2

`define BC_SYNC_STAGES 2 // button synchronizer flops

`endif

/* hdl/bus_console_pkg.sv */
`default_nettype none
`include "bus_console_params.svh"

package bus_console_pkg;

    typedef logic [$clog2(`BC_BANK_DEPTH)-1:0] bank_cnt_t;

    // operator setup sequence
    typedef enum logic [3:0] {
        SLAVE_SEL, RW_SEL, EXT_SEL,
        EXT_WR_M0, EXT_WR_BOTH, EXT_WR_M1,
        START_ADDR_M0, START_ADDR_M1,
        CONFIG, COM_READY, COMMUNICATING, COM_DONE
    } main_state_t;

    typedef enum logic [1:0] {
        CFG_FIRST, CFG_MIDDLE, CFG_LAST, CFG_DONE
    } cfg_state_t;

    // what the command registers do this cycle
    typedef enum logic [3:0] {
        OP_NONE, OP_LATCH_SLAVE, OP_LATCH_RW, OP_LATCH_EXT, OP_SET_BURST,
        OP_LATCH_ADDR, OP_CFG_WORD, OP_CFG_CLEAR, OP_GO, OP_IDLE, OP_READBACK
    } cmd_op_t;

    typedef struct packed {
        logic [1:0]                slave_id;   // 0 = no slave
        logic                      rd_wr;
        logic                      ext_wr;
        logic                      burst;
        logic [`BC_ADDR_WIDTH-1:0] first_addr;
    } mst_setting_t;

    typedef struct packed {
        logic                      start;
        logic                      in_ex;      // 1 = external word from the console
        logic                      rd_wr;
        logic                      burst;
        logic [1:0]                slave_id;
        logic [`BC_ADDR_WIDTH-1:0] address;
        logic [`BC_DATA_WIDTH-1:0] data;
    } mst_cmd_t;

    typedef struct packed {
        logic idle;
        logic ready;
        logic busy;
        logic done;
    } status_led_t;

endpackage

`default_nettype wire

/* hdl/key_strobe.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_console_params.svh"

module key_strobe (
    input  logic clk,
    input  logic rstN,
    input  logic key_n,
    output logic pulse
);
    localparam int S = `BC_SYNC_STAGES;
    localparam int W = S + 1;     // samples that must agree

    // sync[S-1] is the first safe stage, older samples sit above it
    logic [S+W-2:0] sync;
    logic           level;        // accepted level, high = released
    logic [W-1:0]   window;

    assign window = sync[S+W-2:S-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sync  <= '1;
            level <= 1'b1;
        end else begin
            sync <= {sync[S+W-3:0], key_n};
            if (&window || ~|window)
                level <= window[0]; // only a settled window moves the level
        end
    end

    // fires once on the high to low change of the accepted level
    assign pulse = level & ~|window;

    a_single_pulse: assert property (@(posedge clk) disable iff (!rstN) pulse |=> !pulse);

endmodule

`default_nettype wire

/* hdl/console_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_console_params.svh"

module console_ctrl (
    input  logic                                           clk,
    input  logic                                           rstN,
    input  logic                                           step,
    input  logic                                           next_pulse,
    input  logic [`BC_MASTERS-1:0]                         mst_done,
    input  bus_console_pkg::bank_cnt_t    [`BC_MASTERS-1:0] entry_cnt,
    input  bus_console_pkg::mst_setting_t [`BC_MASTERS-1:0] settings,
    input  logic [17:0]                                    sw,
    output bus_console_pkg::cmd_op_t                       op,
    output logic                                           op_master,
    output bus_console_pkg::bank_cnt_t                     cfg_slot,
    output logic                                           cfg_start,
    output logic                                           wr_active,
    output logic                                           wr_master,
    output logic                                           ptr_advance,
    output logic                                           ptr_clear,
    output bus_console_pkg::status_led_t                   led
);
    import bus_console_pkg::*;

    localparam int CNT_W = (`BC_CFG_CLKS > 1) ? $clog2(`BC_CFG_CLKS) : 1;

    main_state_t      state, state_d;
    cfg_state_t       cfg_state;
    logic             cfg_master;   // master being streamed
    bank_cnt_t        slot;
    bank_cnt_t        slot_nxt;
    bank_cnt_t        last_slot;
    logic [CNT_W-1:0] clk_cnt;
    logic             slot_end;

    assign slot_end = (clk_cnt == CNT_W'(`BC_CFG_CLKS - 1));
    assign slot_nxt = slot + 1'b1;
    assign cfg_slot = slot;

    // one slot per entered word plus the first, never fewer than two
    always_comb begin
        if (settings[cfg_master].ext_wr && entry_cnt[cfg_master] != '0)
            last_slot = entry_cnt[cfg_master];
        else
            last_slot = bank_cnt_t'(1);
    end

    always_comb begin
        state_d = state;
        case (state)
            SLAVE_SEL: if (step) state_d = (sw[3:0] == 4'd0) ? COM_DONE : RW_SEL;
            RW_SEL:    if (step) state_d = EXT_SEL;
            EXT_SEL: begin
                if (step) begin
                    case (sw[1:0])
                        2'b00:   state_d = START_ADDR_M0;
                        2'b01:   state_d = EXT_WR_M0;
                        2'b10:   state_d = EXT_WR_M1;
                        default: state_d = EXT_WR_BOTH;
                    endcase
                end
            end
            EXT_WR_M0:     if (step) state_d = START_ADDR_M0;
            EXT_WR_BOTH:   if (step) state_d = EXT_WR_M1;
            EXT_WR_M1:     if (step) state_d = START_ADDR_M0;
            START_ADDR_M0: if (step) state_d = START_ADDR_M1;
            START_ADDR_M1: if (step) state_d = CONFIG;
            CONFIG:        if (cfg_state == CFG_DONE) state_d = COM_READY;
            COM_READY:     if (step) state_d = COMMUNICATING;
            COMMUNICATING: if (&mst_done) state_d = COM_DONE;
            COM_DONE:      state_d = COM_DONE;   // left only by reset
            default:       state_d = SLAVE_SEL;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= SLAVE_SEL;
        end else begin
            state <= state_d;
        end
    end

    // configuration streaming, parked while outside CONFIG
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg_state  <= CFG_FIRST;
            cfg_master <= 1'b0;
            slot       <= '0;
            clk_cnt    <= '0;
        end else if (state != CONFIG) begin
            cfg_state  <= CFG_FIRST;
            cfg_master <= 1'b0;
            slot       <= '0;
            clk_cnt    <= '0;
        end else if (cfg_state != CFG_DONE) begin
            clk_cnt <= slot_end ? '0 : clk_cnt + 1'b1;
            if (slot_end) begin
                case (cfg_state)
                    CFG_FIRST: begin
                        slot      <= slot_nxt;
                        cfg_state <= (last_slot == bank_cnt_t'(1)) ? CFG_LAST : CFG_MIDDLE;
                    end
                    CFG_MIDDLE: begin
                        slot <= slot_nxt;
                        if (slot_nxt == last_slot)
                            cfg_state <= CFG_LAST;
                    end
                    default: begin
                        if (cfg_master) begin
                            cfg_state <= CFG_DONE;
                        end else begin
                            cfg_master <= 1'b1;   // on to the next master
                            slot       <= '0;
                            cfg_state  <= CFG_FIRST;
                        end
                    end
                endcase
            end
        end
    end

    always_comb begin
        op          = OP_NONE;
        op_master   = 1'b0;
        cfg_start   = 1'b0;
        wr_active   = 1'b0;
        wr_master   = 1'b0;
        ptr_advance = 1'b0;
        ptr_clear   = 1'b0;
        case (state)
            SLAVE_SEL: op = OP_LATCH_SLAVE;
            RW_SEL:    op = OP_LATCH_RW;
            EXT_SEL:   op = OP_LATCH_EXT;
            EXT_WR_M0, EXT_WR_BOTH, EXT_WR_M1: begin
                wr_active   = 1'b1;
                wr_master   = (state == EXT_WR_M1);
                op_master   = (state == EXT_WR_M1);
                ptr_clear   = step;
                ptr_advance = next_pulse & ~step; // step wins
                if (next_pulse && !step)
                    op = OP_SET_BURST;
            end
            START_ADDR_M0: op = OP_LATCH_ADDR;
            START_ADDR_M1: begin
                op        = OP_LATCH_ADDR;
                op_master = 1'b1;
            end
            CONFIG: begin
                if (cfg_state == CFG_DONE) begin
                    op = OP_CFG_CLEAR;
                end else begin
                    op        = OP_CFG_WORD;
                    op_master = cfg_master;
                    // first cycle of slot 0 and of the final slot
                    cfg_start = (clk_cnt == '0) &&
                                (cfg_state == CFG_FIRST || cfg_state == CFG_LAST);
                end
            end
            COM_READY: if (step) op = OP_GO;
            COM_DONE:  op = next_pulse ? OP_READBACK : OP_IDLE;
            default:   op = OP_NONE;
        endcase
    end

    always_comb begin
        led.idle  = (state == SLAVE_SEL);
        led.ready = (state == COM_READY);
        led.busy  = (state == COMMUNICATING);
        led.done  = (state == COM_DONE);
    end

endmodule

`default_nettype wire

/* hdl/data_bank.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_console_params.svh"

module data_bank (
    input  logic                                        clk,
    input  logic                                        rstN,
    input  logic                                        wr_active,
    input  logic                                        wr_master,
    input  logic                                        ptr_advance,
    input  logic                                        ptr_clear,
    input  logic [`BC_DATA_WIDTH-1:0]                   sw_data,
    input  logic                                        rd_master,
    input  bus_console_pkg::bank_cnt_t                  rd_slot,
    output bus_console_pkg::bank_cnt_t [`BC_MASTERS-1:0] entry_cnt,
    output logic [`BC_DATA_WIDTH-1:0]                   bank_rdata
);
    import bus_console_pkg::*;

    logic [`BC_DATA_WIDTH-1:0] bank [`BC_MASTERS][`BC_BANK_DEPTH];

    bank_cnt_t                   ptr;        // shared, cleared between masters
    bank_cnt_t [`BC_MASTERS-1:0] press_cnt;  // next-address presses

    // word under the pointer follows the switches
    always_ff @(posedge clk) begin
        if (wr_active)
            bank[wr_master][ptr] <= sw_data;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ptr       <= '0;
            press_cnt <= '0;
        end else if (ptr_clear) begin
            ptr <= '0;
        end else if (ptr_advance) begin
            ptr                  <= ptr + 1'b1;
            press_cnt[wr_master] <= press_cnt[wr_master] + 1'b1;
        end
    end

    // each press closed one word and opened the next
    assign entry_cnt = press_cnt;

    assign bank_rdata = bank[rd_master][rd_slot];

    // the operator must not step past the last bank entry
    a_no_overrun: assert property (@(posedge clk) disable iff (!rstN)
        ptr_advance |-> (ptr != bank_cnt_t'(`BC_BANK_DEPTH - 1)));

endmodule

`default_nettype wire

/* hdl/master_cmd.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_console_params.svh"

module master_cmd (
    input  logic                                           clk,
    input  logic                                           rstN,
    input  bus_console_pkg::cmd_op_t                       op,
    input  logic                                           op_master,
    input  bus_console_pkg::bank_cnt_t                     cfg_slot,
    input  logic                                           cfg_start,
    input  logic [`BC_DATA_WIDTH-1:0]                      bank_rdata,
    input  logic [17:0]                                    sw,
    input  logic [`BC_MASTERS-1:0][`BC_DATA_WIDTH-1:0]     mst_rdata,
    output bus_console_pkg::mst_setting_t [`BC_MASTERS-1:0] settings,
    output bus_console_pkg::mst_cmd_t     [`BC_MASTERS-1:0] mst_cmd,
    output logic [`BC_MASTERS-1:0][`BC_DATA_WIDTH-1:0]     result
);
    import bus_console_pkg::*;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            settings <= '0;
            mst_cmd  <= '0;
        end else begin
            // start is a strobe unless this cycle's op raises it
            for (int m = 0; m < `BC_MASTERS; m++)
                mst_cmd[m].start <= 1'b0;

            case (op)
                OP_LATCH_SLAVE: begin
                    for (int m = 0; m < `BC_MASTERS; m++)
                        settings[m].slave_id <= sw[2*m +: 2];
                end
                OP_LATCH_RW: begin
                    for (int m = 0; m < `BC_MASTERS; m++)
                        settings[m].rd_wr <= sw[m];
                end
                OP_LATCH_EXT: begin
                    for (int m = 0; m < `BC_MASTERS; m++)
                        settings[m].ext_wr <= sw[m];
                end
                OP_SET_BURST:  settings[op_master].burst <= 1'b1;
                OP_LATCH_ADDR: settings[op_master].first_addr <= sw[`BC_ADDR_WIDTH-1:0];
                OP_CFG_WORD: begin
                    mst_cmd[op_master].start    <= cfg_start;
                    mst_cmd[op_master].in_ex    <= 1'b1;
                    mst_cmd[op_master].rd_wr    <= settings[op_master].rd_wr;
                    mst_cmd[op_master].burst    <= settings[op_master].burst;
                    mst_cmd[op_master].slave_id <= settings[op_master].slave_id;
                    mst_cmd[op_master].address  <= settings[op_master].first_addr;
                    mst_cmd[op_master].data     <= bank_rdata;
                end
                OP_CFG_CLEAR: begin
                    for (int m = 0; m < `BC_MASTERS; m++)
                        mst_cmd[m].address <= '0;
                end
                OP_GO: begin
                    for (int m = 0; m < `BC_MASTERS; m++) begin
                        mst_cmd[m].start    <= 1'b1;
                        mst_cmd[m].in_ex    <= 1'b0;   // bus transfer
                        mst_cmd[m].rd_wr    <= settings[m].rd_wr;
                        mst_cmd[m].slave_id <= settings[m].slave_id;
                    end
                end
                OP_READBACK: begin
                    // both masters look at the same new address
                    for (int m = 0; m < `BC_MASTERS; m++)
                        mst_cmd[m].address <= sw[`BC_ADDR_WIDTH-1:0];
                end
                default: ;
            endcase
        end
    end

    // read port of each master, followed while in the done phase
    always_ff @(posedge clk) begin
        if (op == OP_IDLE || op == OP_READBACK)
            result <= mst_rdata;
    end

    // streaming serves one master at a time
    a_cfg_one_start: assert property (@(posedge clk) disable iff (!rstN)
        op == OP_CFG_WORD |=> $onehot0({mst_cmd[1].start, mst_cmd[0].start}));

endmodule

`default_nettype wire

/* hdl/bus_console.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_console_params.svh"

module bus_console (
    input  logic                                       clk,
    input  logic                                       rstN,
    input  logic [17:0]                                sw,
    input  logic                                       key_step_n,
    input  logic                                       key_next_n,
    output bus_console_pkg::mst_cmd_t [`BC_MASTERS-1:0] mst_cmd,
    input  logic [`BC_MASTERS-1:0]                     mst_done,
    input  logic [`BC_MASTERS-1:0][`BC_DATA_WIDTH-1:0] mst_rdata,
    output logic [`BC_MASTERS-1:0][`BC_DATA_WIDTH-1:0] result,
    output bus_console_pkg::status_led_t               led
);
    import bus_console_pkg::*;

    logic                            step;
    logic                            next_pulse;
    cmd_op_t                         op;
    logic                            op_master;
    bank_cnt_t                       cfg_slot;
    logic                            cfg_start;
    logic                            wr_active;
    logic                            wr_master;
    logic                            ptr_advance;
    logic                            ptr_clear;
    bank_cnt_t    [`BC_MASTERS-1:0]  entry_cnt;
    logic [`BC_DATA_WIDTH-1:0]       bank_rdata;
    mst_setting_t [`BC_MASTERS-1:0]  settings;

    key_strobe step_strobe (.clk, .rstN, .key_n(key_step_n), .pulse(step));
    key_strobe next_strobe (.clk, .rstN, .key_n(key_next_n), .pulse(next_pulse));

    console_ctrl u_ctrl (
        .clk, .rstN,
        .step, .next_pulse,
        .mst_done, .entry_cnt, .settings, .sw,
        .op, .op_master,
        .cfg_slot, .cfg_start,
        .wr_active, .wr_master, .ptr_advance, .ptr_clear,
        .led
    );

    data_bank u_bank (
        .clk, .rstN,
        .wr_active, .wr_master, .ptr_advance, .ptr_clear,
        .sw_data(sw[`BC_DATA_WIDTH-1:0]),
        .rd_master(op_master),
        .rd_slot(cfg_slot),
        .entry_cnt,
        .bank_rdata
    );

    master_cmd u_cmd (
        .clk, .rstN,
        .op, .op_master,
        .cfg_slot, .cfg_start,
        .bank_rdata, .sw, .mst_rdata,
        .settings, .mst_cmd, .result
    );

endmodule

`default_nettype wire

/* testbench/bus_console_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_console_params.svh"

module bus_console_checker (
    input  logic                                       clk,
    input  logic                                       rstN,
    input  bus_console_pkg::mst_cmd_t [`BC_MASTERS-1:0] mst_cmd,
    input  logic [`BC_MASTERS-1:0]                     mst_done,
    input  logic [`BC_MASTERS-1:0][`BC_DATA_WIDTH-1:0] result,
    input  bus_console_pkg::status_led_t               led
);
    import bus_console_pkg::*;

    localparam int M   = `BC_MASTERS;
    localparam int DW  = `BC_DATA_WIDTH;
    localparam int AW  = `BC_ADDR_WIDTH;
    localparam int CAP = 32;

    int            value_errs = 0;
    int            fail_errs = 0;
    logic [DW-1:0] cap_data [M][CAP];   // data on the first cycle of each slot
    logic [AW-1:0] cap_addr [M][CAP];
    int            cap_n [M];
    logic          cap_burst [M];
    logic          active [M];
    int            cyc [M];
    int            cfg_order [8];       // master of each config start
    int            cfg_cnt;
    int            go_cnt [M];
    logic          go_in_ex [M];
    logic          go_rd_wr [M];
    logic [1:0]    go_sid [M];
    int            any_starts;
    logic [M-1:0]  prev_done;
    logic          prev_busy;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        fail_errs++;
        $display("FAIL %0t %s", $time, msg);
    endtask

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int m = 0; m < M; m++) begin
                cap_n[m]  = 0;
                active[m] = 1'b0;
                cyc[m]    = 0;
                go_cnt[m] = 0;
            end
            cfg_cnt    = 0;
            any_starts = 0;
            prev_done  = '0;
            prev_busy  = 1'b0;
        end else begin
            // done LED only once both masters reported done
            if (led.done && prev_busy)
                check_val("mst_done before led.done", 32'(prev_done), 32'((1 << M) - 1));
            for (int m = 0; m < M; m++) begin
                if (mst_cmd[m].start) begin
                    any_starts++;
                end
                if (mst_cmd[m].start && led.busy) begin
                    go_cnt[m]++;
                    go_in_ex[m] = mst_cmd[m].in_ex;
                    go_rd_wr[m] = mst_cmd[m].rd_wr;
                    go_sid[m]   = mst_cmd[m].slave_id;
                end else if (mst_cmd[m].start || (active[m] && cyc[m] % `BC_CFG_CLKS == 0)) begin
                    if (mst_cmd[m].start) begin
                        if (cfg_cnt < 8)
                            cfg_order[cfg_cnt] = m;
                        cfg_cnt++;
                        if (!active[m]) begin
                            cap_n[m]     = 0;
                            cyc[m]       = 0;
                            cap_burst[m] = mst_cmd[m].burst;
                        end
                        active[m] = !active[m];   // second start closes the stream
                    end
                    if (cap_n[m] < CAP) begin
                        cap_data[m][cap_n[m]] = mst_cmd[m].data;
                        cap_addr[m][cap_n[m]] = mst_cmd[m].address;
                    end
                    cap_n[m]++;
                end
                if (active[m])
                    cyc[m]++;
            end
            prev_done = mst_done;
            prev_busy = led.busy;
        end
    end

    task automatic check_idle;
        @(negedge clk);
        check_val("led", 32'(led), 32'(4'b1000));
        for (int m = 0; m < M; m++)
            check_val($sformatf("mst_cmd[%0d].start", m), 32'(mst_cmd[m].start), 0);
    endtask

    task automatic check_order;
        @(negedge clk);
        check_val("config start count", cfg_cnt, 4);
        for (int i = 0; i < 4 && i < cfg_cnt; i++)
            check_val($sformatf("config start %0d master", i), cfg_order[i], i / 2);
    endtask

    task automatic check_master(input int m, input int slots, input int known,
                                input logic [DW-1:0] exp_data [`BC_BANK_DEPTH],
                                input logic [AW-1:0] addr, input logic burst);
        @(negedge clk);
        check_val($sformatf("mst_cmd[%0d] slot count", m), cap_n[m], slots);
        check_val($sformatf("mst_cmd[%0d].burst", m), 32'(cap_burst[m]), 32'(burst));
        for (int k = 0; k < cap_n[m] && k < CAP; k++) begin
            check_val($sformatf("mst_cmd[%0d].address slot %0d", m, k),
                      32'(cap_addr[m][k]), 32'(addr));
            if (k < known)
                check_val($sformatf("mst_cmd[%0d].data slot %0d", m, k),
                          32'(cap_data[m][k]), 32'(exp_data[k]));
        end
    endtask

    task automatic check_go(input logic [M-1:0] rd_wr, input logic [M-1:0][1:0] sid);
        @(negedge clk);
        for (int m = 0; m < M; m++) begin
            check_val($sformatf("mst_cmd[%0d] go starts", m), go_cnt[m], 1);
            check_val($sformatf("mst_cmd[%0d].in_ex", m), 32'(go_in_ex[m]), 0);
            check_val($sformatf("mst_cmd[%0d].rd_wr", m), 32'(go_rd_wr[m]), 32'(rd_wr[m]));
            check_val($sformatf("mst_cmd[%0d].slave_id", m), 32'(go_sid[m]), 32'(sid[m]));
        end
    endtask

    task automatic check_no_starts;
        @(negedge clk);
        check_val("start pulse count", any_starts, 0);
    endtask

    task automatic check_readback(input logic [AW-1:0] addr);
        int n;
        n = 0;
        @(negedge clk);
        while (n < 50 && !(mst_cmd[0].address == addr && mst_cmd[1].address == addr &&
               result[0] == DW'(16'hA000 + addr) && result[1] == DW'(16'hA000 + addr))) begin
            @(negedge clk);
            n++;
        end
        for (int m = 0; m < M; m++) begin
            check_val($sformatf("mst_cmd[%0d].address", m), 32'(mst_cmd[m].address), 32'(addr));
            check_val($sformatf("result[%0d]", m), 32'(result[m]), 32'(DW'(16'hA000 + addr)));
        end
    endtask

    task automatic print_counts;
        $display("value errors: %0d, other failures: %0d", value_errs, fail_errs);
    endtask

endmodule

`default_nettype wire

/* testbench/tb_bus_console.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_console_params.svh"

module tb_bus_console;
    import bus_console_pkg::*;

    localparam int M  = `BC_MASTERS;
    localparam int DW = `BC_DATA_WIDTH;
    localparam int AW = `BC_ADDR_WIDTH;
    localparam int D  = `BC_BANK_DEPTH;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic [17:0]          sw;
    logic                 key_step_n;
    logic                 key_next_n;
    mst_cmd_t [M-1:0]     mst_cmd;
    logic [M-1:0]         mst_done = '0;
    logic [M-1:0][DW-1:0] mst_rdata = '0;
    logic [M-1:0][DW-1:0] result;
    status_led_t          led;

    logic [31:0]   rng;
    int            done_delay [M];
    int            done_cnt [M];
    logic [DW-1:0] words0 [D];
    logic [DW-1:0] words1 [D];
    logic [DW-1:0] exp_data [D];
    logic [AW-1:0] addr0, addr1, new_addr;
    int            slots, known;

    bus_console dut0 (.clk, .rstN, .sw, .key_step_n, .key_next_n,
                      .mst_cmd, .mst_done, .mst_rdata, .result, .led);

    bus_console_checker chk0 (.clk, .rstN, .mst_cmd, .mst_done, .result, .led);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // n words entered means n-1 presses; at least two slots
    function automatic int expected_slots(input logic ext, input int nwords,
                                          input logic [DW-1:0] words [D],
                                          output logic [DW-1:0] exp [D], output int kn);
        int s;
        s  = (ext && nwords > 1) ? nwords : 2;
        kn = ext ? ((nwords < s) ? nwords : s) : 0;
        for (int k = 0; k < D; k++)
            exp[k] = (k < kn) ? words[k] : '0;
        return s;
    endfunction

    // master model: done a few cycles after a bus start, data tracks address
    always @(posedge clk) begin
        for (int m = 0; m < M; m++) begin
            mst_rdata[m] <= DW'(16'hA000 + mst_cmd[m].address);
            if (!rstN) begin
                mst_done[m] <= 1'b0;
                done_cnt[m] <= 0;
            end else if (mst_cmd[m].start && !mst_cmd[m].in_ex) begin
                mst_done[m] <= 1'b0;
                done_cnt[m] <= done_delay[m];
            end else if (done_cnt[m] > 1) begin
                done_cnt[m] <= done_cnt[m] - 1;
            end else if (done_cnt[m] == 1) begin
                done_cnt[m] <= 0;
                mst_done[m] <= 1'b1;
            end
        end
    end

    task automatic apply_reset;
        @(posedge clk);
        rstN <= 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
    endtask

    task automatic set_sw(input logic [17:0] v);
        @(posedge clk);
        sw <= v;
    endtask

    task automatic press(input logic use_next);
        @(posedge clk);
        if (use_next)
            key_next_n <= 1'b0;
        else
            key_step_n <= 1'b0;
        repeat (5) @(posedge clk);
        key_next_n <= 1'b1;
        key_step_n <= 1'b1;
        repeat (5) @(posedge clk);
    endtask

    task automatic wait_led(input logic [3:0] want, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (led != want && n < 500) begin
            @(negedge clk);
            n++;
        end
        if (led != want)
            chk0.report_failure({"timed out waiting for ", what});
    endtask

    task automatic finish_run;
        chk0.print_counts();
        if (chk0.value_errs == 0 && chk0.fail_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    initial begin
        rstN       = 1'b0;
        sw         = '0;
        key_step_n = 1'b1;
        key_next_n = 1'b1;
        rng        = 32'h386f8ce5;
        for (int m = 0; m < M; m++)
            done_delay[m] = 3;
        apply_reset();
        chk0.check_idle();
        set_sw(18'h9);               // m0 on slave 1, m1 on slave 2
        press(0);
        wait_led(4'b0000, "setup to leave idle");
        set_sw(18'h1);               // m0 reads, m1 writes
        press(0);
        set_sw(18'h3);               // both take external words
        press(0);
        for (int k = 0; k < 3; k++) begin
            rng       = lcg(rng);
            words0[k] = rng[31:16];
            set_sw({2'b00, words0[k]});
            if (k < 2)
                press(1);
        end
        press(0);
        rng       = lcg(rng);
        words1[0] = rng[31:16];
        set_sw({2'b00, words1[0]});
        press(0);
        rng   = lcg(rng);
        addr0 = rng[27:16];
        set_sw({6'd0, addr0});
        press(0);
        rng   = lcg(rng);
        addr1 = rng[27:16];
        set_sw({6'd0, addr1});
        press(0);
        wait_led(4'b0100, "configuration to finish");
        chk0.check_order();
        slots = expected_slots(1'b1, 3, words0, exp_data, known);
        chk0.check_master(0, slots, known, exp_data, addr0, 1'b1);
        slots = expected_slots(1'b1, 1, words1, exp_data, known);
        chk0.check_master(1, slots, known, exp_data, addr1, 1'b0);
        for (int m = 0; m < M; m++) begin
            rng           = lcg(rng);
            done_delay[m] = 3 + int'(rng[23:16] % 18);
        end
        press(0);
        wait_led(4'b0001, "both masters to finish");
        chk0.check_go(2'b01, {2'd2, 2'd1});
        rng      = lcg(rng);
        new_addr = rng[27:16];
        set_sw({6'd0, new_addr});
        press(1);
        chk0.check_readback(new_addr);

        apply_reset();               // no slaves at all
        chk0.check_idle();
        set_sw(18'h0);
        press(0);
        wait_led(4'b0001, "the done LED without slaves");
        chk0.check_no_starts();

        apply_reset();               // no external words
        chk0.check_idle();
        set_sw(18'h6);
        press(0);
        set_sw(18'h2);
        press(0);
        set_sw(18'h0);
        press(0);
        rng   = lcg(rng);
        addr0 = rng[27:16];
        set_sw({6'd0, addr0});
        press(0);
        rng   = lcg(rng);
        addr1 = rng[27:16];
        set_sw({6'd0, addr1});
        press(0);
        wait_led(4'b0100, "configuration without external words");
        chk0.check_order();
        slots = expected_slots(1'b0, 0, words0, exp_data, known);
        chk0.check_master(0, slots, known, exp_data, addr0, 1'b0);
        chk0.check_master(1, slots, known, exp_data, addr1, 1'b0);
        finish_run();
    end

    // whole run limit
    initial begin
        repeat (20000) @(posedge clk);
        chk0.report_failure("simulation did not finish in time");
        finish_run();
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/bus_console_pkg.sv
hdl/key_strobe.sv
hdl/console_ctrl.sv
hdl/data_bank.sv
hdl/master_cmd.sv
hdl/bus_console.sv
testbench/bus_console_checker.sv
testbench/tb_bus_console.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_bus_console -Mdir obj_dir -o sim_bus_console
	./obj_dir/sim_bus_console | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
